/* Bender.yml */
package:
  name: s1c88

sources:
  - rtl/s1c88_pkg.sv
  - rtl/fetch_if.sv
  - rtl/micro_if.sv
  - rtl/bus_sequencer.sv
  - rtl/instruction_decoder.sv
  - rtl/microcode_engine.sv
  - rtl/datapath.sv
  - rtl/s1c88_top.sv
  - target: test
    files:
      - dv/tb_s1c88.sv

/* dv/s1c88_stimulus.txt */
# M addr data = memory byte, F addr = expected opcode fetch address (sync)
# W addr data = expected bus write in order, addresses in hex
M 0000 00
M 0001 01
M 0100 B4
M 0101 20
M 0102 CE
M 0103 C5
M 0104 01
M 0105 DD
M 0106 10
M 0107 5A
M 0108 44
M 0109 40
M 010A 7C
M 010B 41
M 010C D8
M 010D 50
M 010E 0F
M 010F D9
M 0110 51
M 0111 0F
M 0112 DA
M 0113 52
M 0114 FF
M 0115 00
M 0116 FF
M 2040 C3
M 2050 A6
M 2051 30
M 2052 A6
F 000100
F 000102
F 000105
F 000108
F 00010A
F 00010C
F 00010F
F 000112
F 000115
F 000116
W 012010 5A
W 012041 C3
W 012050 06
W 012051 3F
W 012052 59

/* dv/tb_s1c88.sv */
`timescale 1ns/1ns

module tb_s1c88;
    import s1c88_pkg::*;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [23:0] address_out;
    bus_status_t bus_status;
    logic        read;
    logic        write;
    logic        sync;
    logic        pk;

    // 64 KB memory model addressed by the low 16 address bits
    logic [7:0]  mem [0:65535];
    logic [23:0] exp_fetch[$];
    logic [23:0] exp_waddr[$];
    logic [7:0]  exp_wdata[$];
    logic [7:0]  vec_lo;
    logic [7:0]  vec_hi;
    int          num_records;
    int          f_idx;
    int          w_idx;
    int          read_cnt;
    int          cycles;
    int          limit;
    int          mismatch_cnt;
    int          other_cnt;
    logic        first_sync_seen;
    logic        all_seen;

    s1c88_top i_dut (
        .clk, .reset, .data_in, .data_out, .address_out, .bus_status,
        .read, .write, .sync, .pk
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task load_stimulus;
        int          fd;
        int          c;
        int          n;
        logic [23:0] addr;
        logic [7:0]  data;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h3C;
        num_records = 0;
        fd = $fopen("dv/s1c88_stimulus.txt", "r");
        if (fd == 0)
            return;
        c = $fgetc(fd);
        while (c != -1)
        begin
            if (c == "#")
            begin
                while (c != "\n" && c != -1)
                    c = $fgetc(fd);
            end
            else if (c == "M" || c == "W")
            begin
                n = $fscanf(fd, "%h %h", addr, data);
                assert (n == 2) else
                begin
                    other_cnt++;
                    $display("%0t: malformed memory or write record", $time);
                end
                if (c == "M")
                    mem[addr[15:0]] = data;
                else
                begin
                    exp_waddr.push_back(addr);
                    exp_wdata.push_back(data);
                end
                num_records++;
            end
            else if (c == "F")
            begin
                n = $fscanf(fd, "%h", addr);
                assert (n == 1) else
                begin
                    other_cnt++;
                    $display("%0t: malformed fetch record", $time);
                end
                exp_fetch.push_back(addr);
                num_records++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // strobes belong to the address phase and name the bus cycle type
    task check_strobes;
        assert (!pk) else
        begin
            mismatch_cnt++;
            $display("MISMATCH %0t pk expected 0 got %b", $time, pk);
        end
        assert (!read || bus_status == BUS_MEM_READ) else
        begin
            mismatch_cnt++;
            $display("MISMATCH %0t bus_status (read) expected %0d got %0d",
                     $time, BUS_MEM_READ, bus_status);
        end
        assert (!write || bus_status == BUS_MEM_WRITE) else
        begin
            mismatch_cnt++;
            $display("MISMATCH %0t bus_status (write) expected %0d got %0d",
                     $time, BUS_MEM_WRITE, bus_status);
        end
    endtask

    // the two reads right after reset fetch the vector low byte first
    task track_vector_read;
        if (read_cnt < 2)
        begin
            assert (address_out == 24'(read_cnt)) else
            begin
                mismatch_cnt++;
                $display("MISMATCH %0t address_out (vector read %0d) expected %h got %h",
                         $time, read_cnt, 24'(read_cnt), address_out);
            end
        end
        read_cnt++;
    endtask

    task match_fetch;
        if (!first_sync_seen)
        begin
            first_sync_seen = 1'b1;
            assert (address_out == {8'h00, vec_hi, vec_lo}) else
            begin
                mismatch_cnt++;
                $display("MISMATCH %0t address_out (first fetch) expected %h got %h",
                         $time, {8'h00, vec_hi, vec_lo}, address_out);
            end
        end
        if (f_idx < exp_fetch.size())
        begin
            assert (address_out == exp_fetch[f_idx]) else
            begin
                mismatch_cnt++;
                $display("MISMATCH %0t address_out (fetch %0d) expected %h got %h",
                         $time, f_idx, exp_fetch[f_idx], address_out);
            end
            f_idx++;
            if (f_idx == exp_fetch.size())
                all_seen = 1'b1;
        end
    endtask

    task store_write;
        mem[address_out[15:0]] = data_out;
        assert (w_idx < exp_waddr.size()) else
        begin
            other_cnt++;
            $display("%0t: write to %h with no expected write left", $time, address_out);
        end
        if (w_idx < exp_waddr.size())
        begin
            assert (address_out == exp_waddr[w_idx]) else
            begin
                mismatch_cnt++;
                $display("MISMATCH %0t address_out (write %0d) expected %h got %h",
                         $time, w_idx, exp_waddr[w_idx], address_out);
            end
            assert (data_out == exp_wdata[w_idx]) else
            begin
                mismatch_cnt++;
                $display("MISMATCH %0t data_out (write %0d) expected %h got %h",
                         $time, w_idx, exp_wdata[w_idx], data_out);
            end
            w_idx++;
        end
    endtask

    task report_and_stop;
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    // strobes are sampled as the address phase ends and memory answers in the data phase
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (!reset && (read || write || sync))
            check_strobes();
        if (!reset && read)
        begin
            data_in <= mem[address_out[15:0]];
            track_vector_read();
        end
        if (!reset && write)
            store_write();
        if (!reset && sync)
            match_fetch();
    end

    initial
    begin
        reset = 1'b1;
        data_in = 8'hFF;
        cycles = 0;
        f_idx = 0;
        w_idx = 0;
        read_cnt = 0;
        mismatch_cnt = 0;
        other_cnt = 0;
        first_sync_seen = 1'b0;
        all_seen = 1'b0;
        load_stimulus();
        vec_lo = mem[16'h0000];
        vec_hi = mem[16'h0001];
        limit = 40 * num_records;
        if (num_records == 0)
        begin
            other_cnt++;
            $display("no stimulus records could be read");
        end
        else
        begin
            repeat (4) @(posedge clk);
            assert (!pk && !read && !write && !sync && bus_status == BUS_IDLE
                    && address_out == '1) else
            begin
                other_cnt++;
                $display("%0t: bus outputs are not idle during reset", $time);
            end
            reset <= 1'b0;
            while (!all_seen && cycles < limit)
                @(negedge clk);
            if (!all_seen)
            begin
                other_cnt++;
                $display("timeout after %0d cycles, only %0d of %0d fetches seen",
                         cycles, f_idx, exp_fetch.size());
            end
            else
            begin
                assert (w_idx == exp_waddr.size()) else
                begin
                    other_cnt++;
                    $display("only %0d of %0d expected writes happened",
                             w_idx, exp_waddr.size());
                end
            end
        end
        report_and_stop();
    end
endmodule

/* rtl/bus_sequencer.sv */
`timescale 1ns/1ns

module bus_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [s1c88_pkg::DATA_W-1:0]  data_in,
    input  logic [s1c88_pkg::DATA_W-1:0]  ep,
    input  logic [s1c88_pkg::DATA_W-1:0]  br,
    input  logic [s1c88_pkg::DATA_W-1:0]  wdata,
    output logic [s1c88_pkg::DATA_W-1:0]  data_out,
    output logic [s1c88_pkg::ADDR_W-1:0]  address_out,
    output s1c88_pkg::bus_status_t        bus_status,
    output logic                          read,
    output logic                          write,
    output logic                          sync,
    output logic                          pk,
    output logic [s1c88_pkg::DATA_W-1:0]  rdata,
    output logic                          rvalid,
    fetch_if.seq                          fetch,
    micro_if.seq                          micro
);
    import s1c88_pkg::*;

    seq_state_t        state;
    logic              wait_cnt;
    logic              vec_hi;
    logic              fetching;
    logic              imm_first;
    logic              imm_left;
    logic [15:0]       pc;
    logic [DATA_W-1:0] opcode_q, opext_q, ll_q, imm_q;
    logic              byte_rd, last_byte, bus_op, mem_rd, mem_wr;

    // bytes completing this cycle reach the decoder before the edge
    assign fetch.opcode = (pk && fetching) ? data_in : opcode_q;
    assign fetch.opext  = (pk && state == ST_OPEXT_READ) ? data_in : opext_q;
    assign fetch.imm    = imm_q;

    assign byte_rd   = fetching || state inside {ST_VECTOR_READ, ST_OPEXT_READ, ST_IMM_READ};
    assign last_byte = (fetching && !fetch.need_opext && fetch.need_imm == 2'd0)
                    || (state == ST_OPEXT_READ && fetch.need_imm == 2'd0)
                    || (state == ST_IMM_READ && !imm_left);
    assign bus_op = state == ST_EXECUTE && !fetching && micro.active
                 && micro.op.bus.head.kind == MICRO_BUS;
    assign mem_rd = bus_op && !micro.op.bus.wr;
    assign mem_wr = bus_op && micro.op.bus.wr;

    assign fetch.load = pk && last_byte;
    assign micro.step = pk && state == ST_EXECUTE && micro.active;

    assign read     = !pk && (byte_rd || mem_rd);
    assign write    = !pk && mem_wr;
    assign sync     = !pk && fetching;
    assign data_out = mem_wr ? wdata : '1;
    assign rdata    = data_in;
    assign rvalid   = pk && mem_rd;

    always_comb
    begin
        if (byte_rd || mem_rd)
            bus_status = BUS_MEM_READ;
        else if (mem_wr)
            bus_status = BUS_MEM_WRITE;
        else
            bus_status = BUS_IDLE;
    end

    always_comb
    begin
        if (state == ST_RESET_WAIT)
            address_out = '1;
        else if (state == ST_VECTOR_READ)
            address_out = VECTOR_ADDR + ADDR_W'(vec_hi);
        else if (bus_op && micro.op.bus.mode == ADDR_BR_LL)
            address_out = {ep, br, ll_q};
        else
            address_out = {{(ADDR_W-16){1'b0}}, pc};
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= ST_RESET_WAIT;
            wait_cnt  <= 1'b0;
            pk        <= 1'b0;
            vec_hi    <= 1'b0;
            fetching  <= 1'b0;
            imm_first <= 1'b0;
            imm_left  <= 1'b0;
            pc        <= '0;
        end
        else if (state == ST_RESET_WAIT)
        begin
            wait_cnt <= wait_cnt + 1'b1;
            if (wait_cnt)
                state <= ST_VECTOR_READ;
        end
        else
        begin
            pk <= ~pk;
            // decisions for the next bus cycle are made at the end of the data phase
            if (pk)
            begin
                if (byte_rd && state != ST_VECTOR_READ)
                    pc <= pc + 16'd1;
                imm_first <= 1'b0;
                if (state == ST_VECTOR_READ)
                begin
                    vec_hi <= 1'b1;
                    if (vec_hi)
                    begin
                        pc[15:8] <= data_in;
                        state    <= ST_EXECUTE;
                        fetching <= 1'b1;
                    end
                    else
                        pc[7:0] <= data_in;
                end
                else if (fetching || state == ST_OPEXT_READ)
                begin
                    fetching <= 1'b0;
                    if (fetching && fetch.need_opext)
                        state <= ST_OPEXT_READ;
                    else if (fetch.need_imm != 2'd0)
                    begin
                        state     <= ST_IMM_READ;
                        imm_first <= 1'b1;
                        imm_left  <= fetch.need_imm == 2'd2;
                    end
                    else
                        state <= ST_EXECUTE;
                end
                else if (state == ST_IMM_READ)
                begin
                    imm_left <= 1'b0;
                    if (!imm_left)
                        state <= ST_EXECUTE;
                end
                else if (micro.op.misc.head.done || micro.op.misc.head.nearly_done)
                    fetching <= 1'b1;
            end
        end
    end

    // captured instruction bytes, ll is always the first immediate
    always_ff @(posedge clk)
    begin
        if (pk && fetching)
            opcode_q <= data_in;
        if (pk && state == ST_OPEXT_READ)
            opext_q <= data_in;
        if (pk && state == ST_IMM_READ)
        begin
            imm_q <= data_in;
            if (imm_first)
                ll_q <= data_in;
        end
    end
endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ns

module datapath (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [s1c88_pkg::DATA_W-1:0]  rdata,
    input  logic                          rvalid,
    input  logic [s1c88_pkg::DATA_W-1:0]  imm,
    output logic [s1c88_pkg::DATA_W-1:0]  ep,
    output logic [s1c88_pkg::DATA_W-1:0]  br,
    output logic [s1c88_pkg::DATA_W-1:0]  wdata,
    micro_if.dp                           micro
);
    import s1c88_pkg::*;

    logic [DATA_W-1:0] a, alu_a, alu_r, src;
    logic_op_t         alu_op;

    always_comb
    begin
        case (micro.op.misc.src)
            REG_IMM:   src = imm;
            REG_A:     src = a;
            REG_BR:    src = br;
            REG_EP:    src = ep;
            REG_ALU_A: src = alu_a;
            REG_ALU_R: src = alu_r;
            default:   src = '0;
        endcase
    end

    // latched memory byte combined with #nn
    always_comb
    begin
        case (alu_op)
            LOP_AND: alu_r = alu_a & imm;
            LOP_OR:  alu_r = alu_a | imm;
            LOP_XOR: alu_r = alu_a ^ imm;
            default: alu_r = alu_a;
        endcase
    end

    always_comb
    begin
        case (micro.op.bus.data)
            REG_A:     wdata = a;
            REG_IMM:   wdata = imm;
            REG_ALU_R: wdata = alu_r;
            default:   wdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            a  <= '0;
            br <= '0;
            ep <= '0;
        end
        else if (rvalid)
        begin
            case (micro.op.bus.data)
                REG_A:   a <= rdata;
                REG_BR:  br <= rdata;
                REG_EP:  ep <= rdata;
                default: ;
            endcase
        end
        else if (micro.step && micro.active && micro.op.misc.head.kind == MICRO_MISC)
        begin
            case (micro.op.misc.dst)
                REG_A:   a <= src;
                REG_BR:  br <= src;
                REG_EP:  ep <= src;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rvalid && micro.op.bus.data == REG_ALU_A)
        begin
            alu_a  <= rdata;
            alu_op <= micro.op.bus.head.lop;
        end
    end
endmodule

/* rtl/fetch_if.sv */
`timescale 1ns/1ns

interface fetch_if;
    import s1c88_pkg::*;

    logic [DATA_W-1:0]  opcode;
    logic [DATA_W-1:0]  opext;
    logic [DATA_W-1:0]  imm;
    logic               load;
    logic               need_opext;
    // number of immediate bytes, 0 to 2
    logic [1:0]         need_imm;
    logic [UADDR_W-1:0] entry;

    modport seq (
        output opcode, opext, imm, load,
        input  need_opext, need_imm, entry
    );

    modport dec (
        input  opcode, opext,
        output need_opext, need_imm, entry
    );
endinterface

/* rtl/instruction_decoder.sv */
`timescale 1ns/1ns

module instruction_decoder (
    fetch_if.dec fetch
);
    import s1c88_pkg::*;

    logic [XOP_W-1:0] xop;

    assign fetch.need_opext = fetch.opcode == OPEXT_PREFIX;

    // 0xCE selects the second opcode page
    assign xop = fetch.need_opext ? {2'b01, fetch.opext} : {2'b00, fetch.opcode};

    always_comb
    begin
        case (xop)
            10'h0B4: fetch.need_imm = 2'd1;
            10'h1C5: fetch.need_imm = 2'd1;
            10'h044: fetch.need_imm = 2'd1;
            10'h07C: fetch.need_imm = 2'd1;
            10'h0DD, 10'h0D8, 10'h0D9, 10'h0DA:
                fetch.need_imm = 2'd2;
            default: fetch.need_imm = 2'd0;
        endcase
    end

    // translation table, unknown codes run the no-op at entry 0
    always_comb
    begin
        case (xop)
            10'h0B4: fetch.entry = UADDR_W'(1);
            10'h1C5: fetch.entry = UADDR_W'(2);
            10'h044: fetch.entry = UADDR_W'(3);
            10'h07C: fetch.entry = UADDR_W'(5);
            10'h0DD: fetch.entry = UADDR_W'(6);
            10'h0D8: fetch.entry = UADDR_W'(7);
            10'h0D9: fetch.entry = UADDR_W'(9);
            10'h0DA: fetch.entry = UADDR_W'(11);
            default: fetch.entry = '0;
        endcase
    end
endmodule

/* rtl/micro_if.sv */
`timescale 1ns/1ns

interface micro_if;
    import s1c88_pkg::*;

    micro_op_t op;
    logic      active;
    // end of a bus cycle that ran a micro-op
    logic      step;

    modport eng (
        output op, active,
        input  step
    );

    modport seq (
        input  op, active,
        output step
    );

    modport dp (
        input op, active, step
    );
endinterface

/* rtl/microcode_engine.sv */
`timescale 1ns/1ns

module microcode_engine (
    input  logic clk,
    input  logic reset,
    fetch_if.seq fetch,
    micro_if.eng micro
);
    import s1c88_pkg::*;

    micro_op_t            rom [0:(1 << UADDR_W)-1];
    logic [UADDR_W-1:0]   base;
    logic [UPC_W-1:0]     upc;

    function automatic micro_op_t misc_op(micro_reg_t dst, micro_reg_t src, logic done,
                                          logic nearly);
        micro_op_t w;
        w = '0;
        w.misc.head.kind        = MICRO_MISC;
        w.misc.head.lop         = LOP_NONE;
        w.misc.head.done        = done;
        w.misc.head.nearly_done = nearly;
        w.misc.dst              = dst;
        w.misc.src              = src;
        return w;
    endfunction

    function automatic micro_op_t bus_op(logic wr, micro_reg_t data, logic_op_t lop,
                                         logic done, logic nearly);
        micro_op_t w;
        w = '0;
        w.bus.head.kind        = MICRO_BUS;
        w.bus.head.lop         = lop;
        w.bus.head.done        = done;
        w.bus.head.nearly_done = nearly;
        w.bus.wr               = wr;
        w.bus.mode             = ADDR_BR_LL;
        w.bus.data             = data;
        return w;
    endfunction

    initial
    begin
        for (int i = 0; i < (1 << UADDR_W); i++)
            rom[i] = misc_op(REG_NONE, REG_NONE, 1'b1, 1'b0);
        rom[1]  = misc_op(REG_BR, REG_IMM, 1'b1, 1'b0);
        rom[2]  = misc_op(REG_EP, REG_IMM, 1'b1, 1'b0);
        // the move into A overlaps the next opcode fetch
        rom[3]  = bus_op(1'b0, REG_ALU_A, LOP_NONE, 1'b0, 1'b1);
        rom[4]  = misc_op(REG_A, REG_ALU_A, 1'b1, 1'b0);
        rom[5]  = bus_op(1'b1, REG_A, LOP_NONE, 1'b1, 1'b0);
        rom[6]  = bus_op(1'b1, REG_IMM, LOP_NONE, 1'b1, 1'b0);
        rom[7]  = bus_op(1'b0, REG_ALU_A, LOP_AND, 1'b0, 1'b0);
        rom[8]  = bus_op(1'b1, REG_ALU_R, LOP_NONE, 1'b1, 1'b0);
        rom[9]  = bus_op(1'b0, REG_ALU_A, LOP_OR, 1'b0, 1'b0);
        rom[10] = bus_op(1'b1, REG_ALU_R, LOP_NONE, 1'b1, 1'b0);
        rom[11] = bus_op(1'b0, REG_ALU_A, LOP_XOR, 1'b0, 1'b0);
        rom[12] = bus_op(1'b1, REG_ALU_R, LOP_NONE, 1'b1, 1'b0);
    end

    assign micro.op = rom[base + UADDR_W'(upc)];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            base         <= '0;
            upc          <= '0;
            micro.active <= 1'b0;
        end
        else if (fetch.load)
        begin
            base         <= fetch.entry;
            upc          <= '0;
            micro.active <= 1'b1;
        end
        else if (micro.step)
        begin
            if (micro.op.misc.head.done)
                micro.active <= 1'b0;
            else
                upc <= upc + 1'b1;
        end
    end
endmodule

/* rtl/s1c88_pkg.sv */
package s1c88_pkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 8;
    localparam logic [ADDR_W-1:0] VECTOR_ADDR = '0;
    localparam logic [DATA_W-1:0] OPEXT_PREFIX = 8'hCE;
    localparam int UPC_W = 4;
    localparam int UADDR_W = 9;
    localparam int XOP_W = 10;

    // values as driven on the S1C88 bus_status pins
    typedef enum logic [1:0] {
        BUS_IDLE      = 2'd0,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_t;

    typedef enum logic [2:0] {
        ST_RESET_WAIT,
        ST_VECTOR_READ,
        ST_OPEXT_READ,
        ST_IMM_READ,
        ST_EXECUTE
    } seq_state_t;

    typedef enum logic {MICRO_MISC, MICRO_BUS} micro_type_t;

    typedef enum logic [4:0] {
        REG_NONE,
        REG_IMM,
        REG_A,
        REG_BR,
        REG_EP,
        REG_ALU_A,
        REG_ALU_R
    } micro_reg_t;

    // EP:BR:ll is the only data address mode left
    typedef enum logic {ADDR_BR_LL} micro_addr_t;

    typedef enum logic [1:0] {LOP_NONE, LOP_AND, LOP_OR, LOP_XOR} logic_op_t;

    typedef struct packed {
        micro_type_t kind;
        logic_op_t   lop;
        logic        done;
        logic        nearly_done;
    } micro_head_t;

    typedef struct packed {
        micro_head_t head;
        micro_reg_t  dst;
        micro_reg_t  src;
        logic [4:0]  pad;
    } micro_misc_t;

    typedef struct packed {
        micro_head_t head;
        logic        wr;
        micro_addr_t mode;
        micro_reg_t  data;
        logic [7:0]  pad;
    } micro_bus_t;

    // the head kind tells whether a 20-bit microcode word is misc or bus
    typedef union packed {
        micro_misc_t misc;
        micro_bus_t  bus;
    } micro_op_t;

endpackage

/* rtl/s1c88_top.sv */
`timescale 1ns/1ns

module s1c88_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [s1c88_pkg::DATA_W-1:0]  data_in,
    output logic [s1c88_pkg::DATA_W-1:0]  data_out,
    output logic [s1c88_pkg::ADDR_W-1:0]  address_out,
    output s1c88_pkg::bus_status_t        bus_status,
    output logic                          read,
    output logic                          write,
    output logic                          sync,
    output logic                          pk
);
    import s1c88_pkg::*;

    logic [DATA_W-1:0] ep;
    logic [DATA_W-1:0] br;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;

    fetch_if fetch_bus ();
    micro_if micro_bus ();

    bus_sequencer i_seq (
        .clk, .reset, .data_in, .ep, .br, .wdata,
        .data_out, .address_out, .bus_status, .read, .write, .sync, .pk,
        .rdata, .rvalid,
        .fetch (fetch_bus.seq),
        .micro (micro_bus.seq)
    );

    instruction_decoder i_dec (.fetch(fetch_bus.dec));

    microcode_engine i_eng (.clk, .reset, .fetch(fetch_bus.seq), .micro(micro_bus.eng));

    datapath i_dp (
        .clk, .reset, .rdata, .rvalid, .imm(fetch_bus.imm),
        .ep, .br, .wdata,
        .micro (micro_bus.dp)
    );
endmodule

/* src.f */
rtl/s1c88_pkg.sv
rtl/fetch_if.sv
rtl/micro_if.sv
rtl/bus_sequencer.sv
rtl/instruction_decoder.sv
rtl/microcode_engine.sv
rtl/datapath.sv
rtl/s1c88_top.sv
dv/tb_s1c88.sv
